// File: hdl/aging_defs.svh
`ifndef AGING_DEFS_SVH
`define AGING_DEFS_SVH

// Measurement window in clock cycles
`define AGING_WINDOW 512

// Monitor points per unit, ALU and IU alike
`define AGING_LANES_PER_UNIT 5

// UART bit time in clock cycles
`define AGING_UART_CLKS_PER_BIT 8

// Report frame layout
`define AGING_FRAME_HEADER 8'hA5
`define AGING_FRAME_BYTES 6

`endif

// File: hdl/aging_pkg.sv
`default_nettype none

`include "aging_defs.svh"

package aging_pkg;

  // Saturating mismatch count, one per lane
  typedef logic [3:0] aging_count_t;

  // Largest value a lane count can reach
  localparam aging_count_t AGING_COUNT_MAX = '1;

  // Monitor bits of one unit
  typedef logic [`AGING_LANES_PER_UNIT-1:0] aging_lane_vec_t;

  // All lane counts of one window
  // Lanes 0 to 4 are ALU, lanes 5 to 9 are IU
  typedef aging_count_t [2*`AGING_LANES_PER_UNIT-1:0] aging_snapshot_t;

  // One UART payload byte
  typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

// File: hdl/aging_sensor.sv
`timescale 1ns/1ps
`default_nettype none

`include "aging_defs.svh"

module aging_sensor
  import aging_pkg::*;
(
  input  logic         clk,
  input  logic         reset_i,
  input  logic         main_i,
  input  logic         shadow_i,
  input  logic         window_end_i,
  output aging_count_t count_o
);

  aging_count_t run_count;
  aging_count_t next_count;
  logic         mismatch;

  // Late shadow capture disagrees with main path
  assign mismatch = main_i ^ shadow_i;

  // Count up, stick at the top value
  assign next_count = (mismatch && (run_count != AGING_COUNT_MAX)) ?
                      run_count + 4'd1 : run_count;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      run_count <= '0;
      count_o   <= '0;
    end else if (window_end_i) begin
      // Last cycle of the window still counts
      count_o   <= next_count;
      run_count <= '0;
    end else begin
      run_count <= next_count;
    end
  end

endmodule

`default_nettype wire

// File: hdl/aging_sensor_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "aging_defs.svh"

module aging_sensor_bank
  import aging_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  aging_lane_vec_t alu_main_i,
  input  aging_lane_vec_t alu_shadow_i,
  input  aging_lane_vec_t iu_main_i,
  input  aging_lane_vec_t iu_shadow_i,
  input  logic            ready_i,
  output aging_snapshot_t snapshot_o,
  output logic            snap_valid_o
);

  localparam int unsigned WIN_W = $clog2(`AGING_WINDOW);
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`AGING_WINDOW - 1);

  aging_lane_vec_t alu_main_q1, alu_main_q2;
  aging_lane_vec_t alu_shadow_q1, alu_shadow_q2;
  aging_lane_vec_t iu_main_q1, iu_main_q2;
  aging_lane_vec_t iu_shadow_q1, iu_shadow_q2;

  logic [WIN_W-1:0] win_cnt;
  logic             window_end;
  wire aging_snapshot_t lane_count;

  // Two-stage synchronizers on every monitor bit
  always_ff @(posedge clk) begin
    alu_main_q1   <= alu_main_i;
    alu_main_q2   <= alu_main_q1;
    alu_shadow_q1 <= alu_shadow_i;
    alu_shadow_q2 <= alu_shadow_q1;
    iu_main_q1    <= iu_main_i;
    iu_main_q2    <= iu_main_q1;
    iu_shadow_q1  <= iu_shadow_i;
    iu_shadow_q2  <= iu_shadow_q1;
  end

  // Free-running window timer
  assign window_end = (win_cnt == WIN_LAST);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      win_cnt <= '0;
    end else if (window_end) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  for (genvar i = 0; i < `AGING_LANES_PER_UNIT; i++) begin : g_lane
    aging_sensor u_alu_sensor (
      .clk          (clk),
      .reset_i      (reset_i),
      .main_i       (alu_main_q2[i]),
      .shadow_i     (alu_shadow_q2[i]),
      .window_end_i (window_end),
      .count_o      (lane_count[i])
    );

    aging_sensor u_iu_sensor (
      .clk          (clk),
      .reset_i      (reset_i),
      .main_i       (iu_main_q2[i]),
      .shadow_i     (iu_shadow_q2[i]),
      .window_end_i (window_end),
      .count_o      (lane_count[i+`AGING_LANES_PER_UNIT])
    );
  end

  // Window result is offered only to an idle framer, else dropped
  always_ff @(posedge clk) begin
    if (reset_i) begin
      snap_valid_o <= 1'b0;
    end else begin
      snap_valid_o <= window_end && ready_i;
    end
  end

  // Sensors hold the fresh counts once snap_valid_o is up
  // The framer reads data nibbles only after the header byte
  always_ff @(posedge clk) begin
    if (reset_i) begin
      snapshot_o <= '0;
    end else if (snap_valid_o) begin
      snapshot_o <= lane_count;
    end
  end

endmodule

`default_nettype wire

// File: hdl/aging_report_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aging_defs.svh"

module aging_report_framer
  import aging_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  aging_snapshot_t snapshot_i,
  input  logic            snap_valid_i,
  input  logic            busy_i,
  output logic            ready_o,
  output logic            send_o,
  output uart_byte_t      byte_o
);

  localparam int unsigned IDX_W = $clog2(`AGING_FRAME_BYTES);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`AGING_FRAME_BYTES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETTLE,
    ST_DRAIN
  } state_t;

  state_t           state;
  logic [IDX_W-1:0] byte_idx;
  logic [IDX_W:0]   lane_lo;
  logic [IDX_W:0]   lane_hi;
  uart_byte_t       data_byte;

  // Data byte k pairs lanes 2k+1 and 2k, odd lane on top
  assign lane_lo   = {byte_idx, 1'b0};
  assign lane_hi   = {byte_idx, 1'b1};
  assign data_byte = {snapshot_i[lane_hi], snapshot_i[lane_lo]};

  assign ready_o = (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state    <= ST_IDLE;
      byte_idx <= '0;
      send_o   <= 1'b0;
    end else begin
      send_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (snap_valid_i) begin
            // Header goes out right away, transmitter is free here
            send_o   <= 1'b1;
            byte_idx <= '0;
            state    <= ST_SETTLE;
          end
        end
        ST_SETTLE: begin
          // busy_i rises one cycle after the send pulse
          state <= ST_DRAIN;
        end
        ST_DRAIN: begin
          if (!busy_i) begin
            if (byte_idx == IDX_LAST) begin
              state <= ST_IDLE;
            end else begin
              send_o   <= 1'b1;
              byte_idx <= byte_idx + 1'b1;
              state    <= ST_SETTLE;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Byte register follows each send pulse
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      byte_o <= `AGING_FRAME_HEADER;
    end else if ((state == ST_DRAIN) && !busy_i) begin
      byte_o <= data_byte;
    end
  end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "aging_defs.svh"

module uart_tx
  import aging_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       send_i,
  input  uart_byte_t byte_i,
  output logic       txd_o,
  output logic       busy_o
);

  localparam int unsigned DIV_W = $clog2(`AGING_UART_CLKS_PER_BIT);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`AGING_UART_CLKS_PER_BIT - 1);

  // Start, eight data bits, stop
  localparam logic [3:0] BIT_LAST = 4'd9;

  logic [DIV_W-1:0] baud_cnt;
  logic             baud_tick;
  logic [3:0]       bit_cnt;
  logic [8:0]       shift_q;

  assign baud_tick = (baud_cnt == DIV_LAST);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_o   <= 1'b0;
      txd_o    <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy_o) begin
      if (send_i) begin
        busy_o   <= 1'b1;
        txd_o    <= 1'b0;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (baud_tick) begin
      baud_cnt <= '0;
      if (bit_cnt == BIT_LAST) begin
        // Stop bit done, line back to idle
        busy_o <= 1'b0;
        txd_o  <= 1'b1;
      end else begin
        txd_o   <= shift_q[0];
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Data LSB first, stop bit parked above the byte
  always_ff @(posedge clk) begin
    if (!busy_o && send_i) begin
      shift_q <= {1'b1, byte_i};
    end else if (busy_o && baud_tick) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/aging_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module aging_monitor_top
  import aging_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  aging_lane_vec_t alu_main_i,
  input  aging_lane_vec_t alu_shadow_i,
  input  aging_lane_vec_t iu_main_i,
  input  aging_lane_vec_t iu_shadow_i,
  output logic            txd_o
);

  aging_snapshot_t snapshot;
  logic            snap_valid;
  logic            framer_ready;
  logic            tx_send;
  uart_byte_t      tx_byte;
  logic            tx_busy;

  // Per-window mismatch counts
  aging_sensor_bank u_sensor_bank (
    .clk          (clk),
    .reset_i      (reset_i),
    .alu_main_i   (alu_main_i),
    .alu_shadow_i (alu_shadow_i),
    .iu_main_i    (iu_main_i),
    .iu_shadow_i  (iu_shadow_i),
    .ready_i      (framer_ready),
    .snapshot_o   (snapshot),
    .snap_valid_o (snap_valid)
  );

  // Snapshot to byte stream
  aging_report_framer u_report_framer (
    .clk          (clk),
    .reset_i      (reset_i),
    .snapshot_i   (snapshot),
    .snap_valid_i (snap_valid),
    .busy_i       (tx_busy),
    .ready_o      (framer_ready),
    .send_o       (tx_send),
    .byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .reset_i (reset_i),
    .send_i  (tx_send),
    .byte_i  (tx_byte),
    .txd_o   (txd_o),
    .busy_o  (tx_busy)
  );

endmodule

`default_nettype wire

// File: dv/aging_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aging_defs.svh"

module aging_monitor_tb
  import aging_pkg::*;
();

  localparam int LANES         = 2 * `AGING_LANES_PER_UNIT;
  localparam int NUM_WINDOWS   = 18;
  localparam int WINDOW        = `AGING_WINDOW;
  localparam int BIT_CLKS      = `AGING_UART_CLKS_PER_BIT;
  localparam int MIS_START     = 16;
  localparam int BYTE_TIMEOUT  = 4 * 10 * BIT_CLKS;
  localparam int FRAME_TIMEOUT = 2 * WINDOW;
  localparam int RESET_TIMEOUT = 100;

  logic            clk;
  logic            reset_i;
  aging_lane_vec_t alu_main_i;
  aging_lane_vec_t alu_shadow_i;
  aging_lane_vec_t iu_main_i;
  aging_lane_vec_t iu_shadow_i;
  logic            txd_o;

  // Injected mismatch lengths, LANES entries per window
  logic [7:0] inj_mem [0:NUM_WINDOWS*LANES-1];
  int         cyc;
  integer     seed;

  aging_monitor_top u_aging_monitor_top (
    .clk          (clk),
    .reset_i      (reset_i),
    .alu_main_i   (alu_main_i),
    .alu_shadow_i (alu_shadow_i),
    .iu_main_i    (iu_main_i),
    .iu_shadow_i  (iu_shadow_i),
    .txd_o        (txd_o)
  );

  always #10 clk = ~clk;

  // Cycle index matches the window timer after reset release
  always @(posedge clk) begin
    if (reset_i) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // A lane saturates at 15
  function automatic aging_count_t expected_count(input int n);
    if (n > 15) begin
      return aging_count_t'(15);
    end
    return aging_count_t'(n);
  endfunction

  // Lanes whose shadow bit is flipped in window cycle k
  function automatic logic [LANES-1:0] shadow_mask(input int w, input int k);
    logic [LANES-1:0] mask;
    int               n;
    mask = '0;
    for (int j = 0; j < LANES; j++) begin
      n = inj_mem[w*LANES+j];
      if (k >= MIS_START && k < MIS_START + n) begin
        mask[j] = 1'b1;
      end
    end
    return mask;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got 0x%02h, expected 0x%02h",
                         $time, what, got, exp));
    end
  endtask

  task automatic check_count(input aging_count_t got, input aging_count_t exp,
                             input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s count %0d, expected %0d",
                         $time, what, got, exp));
    end
  endtask

  task automatic drive_cycle(input int w, input int k);
    logic [LANES-1:0] main_bits;
    logic [LANES-1:0] mask;
    main_bits = LANES'($random(seed));
    mask      = shadow_mask(w, k);
    alu_main_i   <= main_bits[4:0];
    alu_shadow_i <= main_bits[4:0] ^ mask[4:0];
    iu_main_i    <= main_bits[9:5];
    iu_shadow_i  <= main_bits[9:5] ^ mask[9:5];
  endtask

  // Line must stay idle up to the given cycle
  task automatic watch_idle_until(input int last_cyc, input string what);
    while (cyc < last_cyc) begin
      @(negedge clk);
      if (txd_o !== 1'b1) begin
        fail_run($sformatf("unexpected activity on txd at cycle %0d, %s", cyc, what));
      end
    end
  endtask

  // UART line decoder, samples near the middle of each bit
  task automatic recv_byte(output uart_byte_t b, output int start_cyc,
                           input int timeout, input string what);
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < timeout) begin
      @(negedge clk);
      if (txd_o === 1'b0) begin
        seen = 1'b1;
      end else begin
        waited++;
      end
    end
    if (!seen) begin
      fail_run($sformatf("timeout, no start bit for %s within %0d cycles", what, timeout));
    end
    start_cyc = cyc;
    repeat (BIT_CLKS/2) @(negedge clk);
    if (txd_o !== 1'b0) begin
      fail_run($sformatf("start bit of %s is shorter than half a bit", what));
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = txd_o;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (txd_o !== 1'b1) begin
      fail_run($sformatf("stop bit of %s is not high", what));
    end
  endtask

  task automatic check_frame(input int w);
    uart_byte_t got;
    int         start_cyc;
    int         base;
    base = w * LANES;
    recv_byte(got, start_cyc, FRAME_TIMEOUT, $sformatf("frame %0d", w));
    // Frame belongs right after the end of its own window
    if (start_cyc / WINDOW != w + 1) begin
      fail_run($sformatf("frame %0d started at cycle %0d, not after its own window",
                         w, start_cyc));
    end
    check_byte(got, `AGING_FRAME_HEADER, $sformatf("frame %0d header", w));
    for (int k = 0; k < `AGING_FRAME_BYTES - 1; k++) begin
      recv_byte(got, start_cyc, BYTE_TIMEOUT, $sformatf("frame %0d byte %0d", w, k + 1));
      check_count(got[3:0], expected_count(inj_mem[base+2*k]),
                  $sformatf("frame %0d lane %0d", w, 2*k));
      check_count(got[7:4], expected_count(inj_mem[base+2*k+1]),
                  $sformatf("frame %0d lane %0d", w, 2*k + 1));
    end
    // Six bytes only, nothing more until the next window ends
    watch_idle_until((w + 2) * WINDOW - 1, $sformatf("after frame %0d", w));
  endtask

  // Stimulus
  initial begin
    clk          = 1'b0;
    reset_i      = 1'b1;
    alu_main_i   = '0;
    alu_shadow_i = '0;
    iu_main_i    = '0;
    iu_shadow_i  = '0;
    seed         = 27;
    $readmemh("dv/aging_input.txt", inj_mem);
    if ($isunknown(inj_mem[NUM_WINDOWS*LANES-1])) begin
      fail_run("input file dv/aging_input.txt is missing or too short");
    end
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    for (int w = 0; w < NUM_WINDOWS; w++) begin
      for (int k = 0; k < WINDOW; k++) begin
        drive_cycle(w, k);
        @(posedge clk);
      end
    end
    // Quiet lanes afterwards
    alu_main_i   <= '0;
    alu_shadow_i <= '0;
    iu_main_i    <= '0;
    iu_shadow_i  <= '0;
  end

  // Checker
  initial begin
    int waited;
    waited = 0;
    while (reset_i !== 1'b0 && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (reset_i !== 1'b0) begin
      fail_run("reset was never released");
    end
    watch_idle_until(WINDOW - 1, "before the first window end");
    for (int w = 0; w < NUM_WINDOWS; w++) begin
      check_frame(w);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/aging_input.txt
// One line per window: mismatch cycles to inject on lanes 0..9, hex
// Lanes 0..4 are ALU bits 0..4, lanes 5..9 are IU bits 0..4
00 01 02 03 04 05 06 07 08 09
09 08 07 06 05 04 03 02 01 00
0F 10 11 12 13 14 0E 0D 0C 0B
01 03 05 07 09 0B 0D 0F 11 13
14 12 10 0E 0C 0A 08 06 04 02
00 0F 01 0E 02 0D 03 0C 04 0B
0A 05 0B 06 0C 07 0D 08 0E 00
13 00 11 02 0F 04 0D 06 0B 08
03 07 0B 0F 13 00 04 08 0C 10
10 0C 08 04 00 14 0F 0A 05 01
02 04 06 08 0A 0C 0E 10 12 14
0E 0A 06 02 11 13 09 05 01 00
05 0A 0F 14 00 03 06 09 0C 12
07 0E 00 01 08 0F 10 09 02 0A
0B 02 0D 04 0F 06 11 08 13 0A
00 14 01 13 02 12 03 11 04 10
0C 0D 0E 0F 10 11 12 13 14 0B
06 01 0A 03 0E 05 12 07 00 09

// File: flist.f
+incdir+hdl
hdl/aging_pkg.sv
hdl/aging_sensor.sv
hdl/aging_sensor_bank.sv
hdl/aging_report_framer.sv
hdl/uart_tx.sv
hdl/aging_monitor_top.sv
dv/aging_monitor_tb.sv
